// File: verilog/div_cfg.svh
// divide unit configuration
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// ==============================
// datapath widths
// ==============================
`define DIV_XLEN 64 // full register width
`define DIV_HLEN 32 // W form width

// ==============================
// one-hot operation codes
// ==============================
`define DIV_OP_REM   8'b1000_0000 // signed remainder
`define DIV_OP_REMU  8'b0100_0000
`define DIV_OP_REMUW 8'b0010_0000
`define DIV_OP_REMW  8'b0001_0000
`define DIV_OP_DIV   8'b0000_1000 // signed quotient
`define DIV_OP_DIVU  8'b0000_0100
`define DIV_OP_DIVUW 8'b0000_0010
`define DIV_OP_DIVW  8'b0000_0001

`endif

// File: verilog/div_pkg.sv
// divide unit shared types
`include "div_cfg.svh"

package div_pkg;

  // ==============================
  // vector types
  // ==============================

  // operands, results and magnitudes
  typedef logic [`DIV_XLEN-1:0] xlen_t;

  // remainder in the upper half, quotient in the lower half
  typedef logic [2*`DIV_XLEN-1:0] dword_t;

  typedef logic [7:0] div_op_t; // one-hot op code

  // remaining iterations, 0 to 64
  typedef logic [6:0] iter_cnt_t;

  // ==============================
  // control FSM
  // ==============================
  typedef enum logic [1:0] {
    ST_IDLE, // waiting for a request
    ST_ITER, // one quotient bit per cycle
    ST_DONE  // holding result
  } div_state_e;

endpackage

// File: verilog/div_operand_prep.sv
// divider operand conditioning
`include "div_cfg.svh"

module div_operand_prep (
  input  div_pkg::div_op_t op_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  output div_pkg::xlen_t   dividend_mag_o,
  output div_pkg::xlen_t   divisor_mag_o,
  output logic             quot_neg_o,
  output logic             rem_neg_o,
  output logic             special_o,
  output div_pkg::xlen_t   special_result_o
);
  import div_pkg::*;

  localparam int XL = `DIV_XLEN;
  localparam int HL = `DIV_HLEN;

  // op class decode
  logic is_w;
  logic is_signed;
  logic is_rem;

  // widened operands
  xlen_t dividend_sext;
  xlen_t divisor_sext;
  xlen_t dividend_ext;
  xlen_t divisor_ext;

  // sign and magnitude
  logic  dividend_neg;
  logic  divisor_neg;
  xlen_t dividend_abs;
  xlen_t divisor_abs;

  // special cases
  logic  div_zero;
  logic  overflow;
  xlen_t dividend_res;

  // ==============================
  // op decode
  // ==============================
  assign is_w      = |(op_i & (`DIV_OP_REMUW | `DIV_OP_REMW | `DIV_OP_DIVUW | `DIV_OP_DIVW));
  assign is_signed = |(op_i & (`DIV_OP_REM | `DIV_OP_REMW | `DIV_OP_DIV | `DIV_OP_DIVW));
  assign is_rem    = |(op_i & (`DIV_OP_REM | `DIV_OP_REMU | `DIV_OP_REMUW | `DIV_OP_REMW));

  // ==============================
  // width and sign handling
  // ==============================
  assign dividend_sext = {{(XL-HL){dividend_i[HL-1]}}, dividend_i[HL-1:0]};
  assign divisor_sext  = {{(XL-HL){divisor_i[HL-1]}}, divisor_i[HL-1:0]};

  // unsigned W forms only look at the low half
  assign dividend_ext = !is_w     ? dividend_i    :
                        is_signed ? dividend_sext :
                                    {{(XL-HL){1'b0}}, dividend_i[HL-1:0]};
  assign divisor_ext  = !is_w     ? divisor_i     :
                        is_signed ? divisor_sext  :
                                    {{(XL-HL){1'b0}}, divisor_i[HL-1:0]};

  assign dividend_neg = is_signed & dividend_ext[XL-1];
  assign divisor_neg  = is_signed & divisor_ext[XL-1];

  assign dividend_abs = dividend_neg ? -dividend_ext : dividend_ext;
  assign divisor_abs  = divisor_neg  ? -divisor_ext  : divisor_ext;

  // W dividend goes to the top so 32 shifts bring it all in
  assign dividend_mag_o = is_w ? {dividend_abs[HL-1:0], {(XL-HL){1'b0}}} : dividend_abs;
  assign divisor_mag_o  = divisor_abs; // upper half is zero for W

  assign quot_neg_o = dividend_neg ^ divisor_neg;
  assign rem_neg_o  = dividend_neg; // remainder follows the dividend

  // ==============================
  // divide by zero and overflow
  // ==============================
  assign div_zero = is_w ? (divisor_i[HL-1:0] == '0) : (divisor_i == '0);

  // most negative value divided by minus one
  assign overflow = is_signed & (is_w ?
                    (dividend_i[HL-1:0] == {1'b1, {(HL-1){1'b0}}}) &&
                    (&divisor_i[HL-1:0]) :
                    (dividend_i == {1'b1, {(XL-1){1'b0}}}) && (&divisor_i));

  assign special_o = div_zero | overflow;

  assign dividend_res = is_w ? dividend_sext : dividend_i;

  // ISA defined answers
  assign special_result_o = div_zero ? (is_rem ? dividend_res : '1) :
                            overflow ? (is_rem ? '0 : dividend_res) :
                                       '0;

endmodule

// File: verilog/div_iter_core.sv
// restoring divider iteration core
`include "div_cfg.svh"

module div_iter_core (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             div_valid_i,
  input  logic             result_ready_i,
  input  div_pkg::div_op_t op_i,
  input  div_pkg::xlen_t   dividend_mag_i,
  input  div_pkg::xlen_t   divisor_mag_i,
  input  logic             quot_neg_i,
  input  logic             rem_neg_i,
  input  logic             special_i,
  input  div_pkg::xlen_t   special_result_i,
  output logic             div_ready_o,
  output logic             result_valid_o,
  output div_pkg::div_op_t op_o,
  output div_pkg::xlen_t   quotient_o,
  output div_pkg::xlen_t   remainder_o,
  output logic             quot_neg_o,
  output logic             rem_neg_o,
  output logic             special_o
);
  import div_pkg::*;

  localparam int XL = `DIV_XLEN;
  localparam int HL = `DIV_HLEN;

  div_state_e state;
  div_state_e state_nxt;
  iter_cnt_t  cnt;        // iterations left

  dword_t     rq;         // {remainder, quotient}
  dword_t     rq_shift;
  xlen_t      divisor_r;
  div_op_t    op_r;
  logic       quot_neg_r;
  logic       rem_neg_r;
  logic       special_r;

  logic       accept;
  logic       is_w;
  logic       last_iter;
  logic [XL:0] trial;     // sign bit on top

  // ==============================
  // handshake
  // ==============================
  assign div_ready_o    = (state == ST_IDLE);
  assign result_valid_o = (state == ST_DONE);
  assign accept         = div_valid_i & div_ready_o;

  assign is_w      = |(op_i & (`DIV_OP_REMUW | `DIV_OP_REMW | `DIV_OP_DIVUW | `DIV_OP_DIVW));
  assign last_iter = (cnt == iter_cnt_t'(1));

  // ==============================
  // FSM
  // ==============================
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          state_nxt = special_i ? ST_DONE : ST_ITER; // special cases skip the loop
        end
      end
      ST_ITER: begin
        if (last_iter) begin
          state_nxt = ST_DONE;
        end
      end
      ST_DONE: begin
        if (result_ready_i) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        cnt <= is_w ? iter_cnt_t'(HL) : iter_cnt_t'(XL);
      end else if (state == ST_ITER) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // ==============================
  // shift and subtract datapath
  // ==============================
  assign rq_shift = rq << 1;

  // partial remainder after the shift, minus divisor
  assign trial = rq[2*XL-1:XL-1] - {1'b0, divisor_r};

  always_ff @(posedge clk) begin
    if (accept) begin
      op_r       <= op_i;
      quot_neg_r <= quot_neg_i;
      rem_neg_r  <= rem_neg_i;
      special_r  <= special_i;
      divisor_r  <= divisor_mag_i;
      // special answer parks in the quotient half
      rq <= {{XL{1'b0}}, special_i ? special_result_i : dividend_mag_i};
    end else if (state == ST_ITER) begin
      if (trial[XL]) begin
        rq <= rq_shift; // negative so restore, quotient bit 0
      end else begin
        rq <= {trial[XL-1:0], rq_shift[XL-1:1], 1'b1};
      end
    end
  end

  // ==============================
  // outputs
  // ==============================
  assign op_o        = op_r;
  assign quotient_o  = rq[XL-1:0];
  assign remainder_o = rq[2*XL-1:XL];
  assign quot_neg_o  = quot_neg_r;
  assign rem_neg_o   = rem_neg_r;
  assign special_o   = special_r;

endmodule

// File: verilog/div_result_sel.sv
// divider result selection
`include "div_cfg.svh"

module div_result_sel (
  input  div_pkg::div_op_t op_i,
  input  div_pkg::xlen_t   quotient_i,
  input  div_pkg::xlen_t   remainder_i,
  input  logic             quot_neg_i,
  input  logic             rem_neg_i,
  input  logic             special_i,
  input  div_pkg::xlen_t   special_result_i,
  output div_pkg::xlen_t   result_o
);
  import div_pkg::*;

  localparam int XL = `DIV_XLEN;
  localparam int HL = `DIV_HLEN;

  logic  is_w;
  logic  is_rem;
  xlen_t quot_fix;
  xlen_t rem_fix;
  xlen_t raw;
  xlen_t raw_w;

  // ==============================
  // op decode
  // ==============================
  assign is_w   = |(op_i & (`DIV_OP_REMUW | `DIV_OP_REMW | `DIV_OP_DIVUW | `DIV_OP_DIVW));
  assign is_rem = |(op_i & (`DIV_OP_REM | `DIV_OP_REMU | `DIV_OP_REMUW | `DIV_OP_REMW));

  // ==============================
  // sign correction
  // ==============================
  assign quot_fix = quot_neg_i ? -quotient_i  : quotient_i;
  assign rem_fix  = rem_neg_i  ? -remainder_i : remainder_i;

  assign raw = is_rem ? rem_fix : quot_fix;

  // W results are sign extended from bit 31
  assign raw_w = {{(XL-HL){raw[HL-1]}}, raw[HL-1:0]};

  // special answer is already final
  assign result_o = special_i ? special_result_i :
                    is_w      ? raw_w            :
                                raw;

endmodule

// File: verilog/div_unit.sv
// integer divide unit
module div_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             div_valid_i,
  input  div_pkg::div_op_t div_op_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  output logic             div_ready_o,
  input  logic             result_ready_i,
  output logic             result_valid_o,
  output div_pkg::xlen_t   result_o
);
  import div_pkg::*;

  // prep to core
  xlen_t   dividend_mag;
  xlen_t   divisor_mag;
  logic    prep_quot_neg;
  logic    prep_rem_neg;
  logic    prep_special;
  xlen_t   prep_special_result;

  // core to result select
  div_op_t op_r;
  xlen_t   quotient;
  xlen_t   remainder;
  logic    quot_neg;
  logic    rem_neg;
  logic    special;

  div_operand_prep i_operand_prep (
    .op_i             (div_op_i),
    .dividend_i       (dividend_i),
    .divisor_i        (divisor_i),
    .dividend_mag_o   (dividend_mag),
    .divisor_mag_o    (divisor_mag),
    .quot_neg_o       (prep_quot_neg),
    .rem_neg_o        (prep_rem_neg),
    .special_o        (prep_special),
    .special_result_o (prep_special_result)
  );

  div_iter_core i_iter_core (
    .clk              (clk),
    .rst_n            (rst_n),
    .div_valid_i      (div_valid_i),
    .result_ready_i   (result_ready_i),
    .op_i             (div_op_i),
    .dividend_mag_i   (dividend_mag),
    .divisor_mag_i    (divisor_mag),
    .quot_neg_i       (prep_quot_neg),
    .rem_neg_i        (prep_rem_neg),
    .special_i        (prep_special),
    .special_result_i (prep_special_result),
    .div_ready_o      (div_ready_o),
    .result_valid_o   (result_valid_o),
    .op_o             (op_r),
    .quotient_o       (quotient),
    .remainder_o      (remainder),
    .quot_neg_o       (quot_neg),
    .rem_neg_o        (rem_neg),
    .special_o        (special)
  );

  // stored special answer comes back in the quotient field
  div_result_sel i_result_sel (
    .op_i             (op_r),
    .quotient_i       (quotient),
    .remainder_i      (remainder),
    .quot_neg_i       (quot_neg),
    .rem_neg_i        (rem_neg),
    .special_i        (special),
    .special_result_i (quotient),
    .result_o         (result_o)
  );

endmodule

// File: bench/div_unit_tb.sv
// divide unit testbench
`include "div_cfg.svh"

module div_unit_tb;
  import div_pkg::*;

  localparam int N_64      = 300; // random 64-bit ops
  localparam int N_W       = 300; // random W ops
  localparam int N_SPECIAL = 12;  // zero divisor and overflow
  localparam int N_BP      = 200; // ops under back-pressure
  localparam int N_OPS     = N_64 + N_W + N_SPECIAL + N_BP;
  localparam int MAX_LAT   = 67;

  localparam xlen_t MIN_X = 64'h8000_0000_0000_0000;
  localparam logic [31:0] MIN_W = 32'h8000_0000;

  localparam div_op_t OPS_64 [4] = '{`DIV_OP_DIV, `DIV_OP_DIVU, `DIV_OP_REM, `DIV_OP_REMU};
  localparam div_op_t OPS_W [4]  = '{`DIV_OP_DIVW, `DIV_OP_DIVUW, `DIV_OP_REMW, `DIV_OP_REMUW};

  logic    clk;
  logic    rst_n;
  logic    div_valid_i;
  div_op_t div_op_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    div_ready_o;
  logic    result_ready_i;
  logic    result_valid_o;
  xlen_t   result_o;

  div_unit i_div_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .div_ready_o    (div_ready_o),
    .result_ready_i (result_ready_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  always #10 clk = ~clk;

  // ==============================
  // error handling and checks
  // ==============================
  task automatic fail_and_stop(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      fail_and_stop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_and_stop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // ==============================
  // reference model
  // ==============================
  function automatic xlen_t model_result(input div_op_t op, input xlen_t a, input xlen_t b,
                                         output bit special);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] sa_w;
    logic signed [31:0] sb_w;
    logic [31:0]        res_w;
    xlen_t              res;
    bit                 w_form;
    sa      = a;
    sb      = b;
    sa_w    = a[31:0];
    sb_w    = b[31:0];
    special = 1'b0;
    w_form  = 1'b0;
    res     = '0;
    res_w   = '0;
    case (op)
      `DIV_OP_DIV, `DIV_OP_REM: begin
        if (b == '0) begin
          special = 1'b1;
          res     = (op == `DIV_OP_DIV) ? '1 : a;
        end else if (a == MIN_X && b == '1) begin
          special = 1'b1; // signed overflow
          res     = (op == `DIV_OP_DIV) ? a : '0;
        end else begin
          res = (op == `DIV_OP_DIV) ? xlen_t'(sa / sb) : xlen_t'(sa % sb);
        end
      end
      `DIV_OP_DIVU, `DIV_OP_REMU: begin
        special = (b == '0);
        if (special) begin
          res = (op == `DIV_OP_DIVU) ? '1 : a;
        end else begin
          res = (op == `DIV_OP_DIVU) ? a / b : a % b;
        end
      end
      `DIV_OP_DIVW, `DIV_OP_REMW: begin
        w_form = 1'b1;
        if (b[31:0] == '0) begin
          special = 1'b1;
          res_w   = (op == `DIV_OP_DIVW) ? '1 : a[31:0];
        end else if (a[31:0] == MIN_W && b[31:0] == '1) begin
          special = 1'b1;
          res_w   = (op == `DIV_OP_DIVW) ? a[31:0] : '0;
        end else begin
          res_w = (op == `DIV_OP_DIVW) ? 32'(sa_w / sb_w) : 32'(sa_w % sb_w);
        end
      end
      `DIV_OP_DIVUW, `DIV_OP_REMUW: begin
        w_form  = 1'b1;
        special = (b[31:0] == '0);
        if (special) begin
          res_w = (op == `DIV_OP_DIVUW) ? '1 : a[31:0];
        end else begin
          res_w = (op == `DIV_OP_DIVUW) ? a[31:0] / b[31:0] : a[31:0] % b[31:0];
        end
      end
      default: ;
    endcase
    if (w_form) begin
      res = {{32{res_w[31]}}, res_w}; // W results sign extend
    end
    return res;
  endfunction

  // ==============================
  // stimulus helpers
  // ==============================
  function automatic xlen_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // small magnitudes of either sign mixed in with wide values
  function automatic xlen_t mixed_value();
    xlen_t v;
    case ($urandom_range(3))
      0: v = xlen_t'($urandom_range(1, 15));
      1: v = -xlen_t'($urandom_range(1, 15));
      2: v = xlen_t'($urandom);
      default: v = rand_word();
    endcase
    return v;
  endfunction

  // called on a falling edge with the unit idle
  task automatic run_op(input div_op_t op, input xlen_t a, input xlen_t b, input bit backpress);
    xlen_t exp_res;
    bit    special;
    int    cycles;
    int    holds;
    exp_res = model_result(op, a, b, special);
    check_flag("div_ready_o", div_ready_o, 1'b1);
    div_valid_i = 1'b1;
    div_op_i    = op;
    dividend_i  = a;
    divisor_i   = b;
    @(negedge clk); // accepting edge has passed
    div_valid_i = 1'b0;
    dividend_i  = rand_word(); // operands only held for one cycle
    divisor_i   = rand_word();
    check_flag("div_ready_o", div_ready_o, 1'b0);
    if (special) begin
      check_flag("result_valid_o", result_valid_o, 1'b1);
    end
    cycles = 1;
    while (!result_valid_o) begin
      if (cycles >= MAX_LAT) begin
        fail_and_stop("Result took longer than 67 cycles");
      end
      result_ready_i = backpress ? ($urandom_range(1) == 1) : 1'b1; // ignored while busy
      @(negedge clk);
      cycles++;
      check_flag("div_ready_o", div_ready_o, 1'b0);
    end
    check_result("result_o", result_o, exp_res);
    holds = 0;
    result_ready_i = backpress ? ($urandom_range(2) == 0) : 1'b1;
    while (!result_ready_i) begin
      @(negedge clk);
      holds++;
      check_flag("result_valid_o", result_valid_o, 1'b1);
      check_flag("div_ready_o", div_ready_o, 1'b0);
      check_result("result_o", result_o, exp_res); // must not move while stalled
      result_ready_i = (holds >= 16) || ($urandom_range(2) == 0);
    end
    @(negedge clk); // delivered
    result_ready_i = 1'b0;
    check_flag("result_valid_o", result_valid_o, 1'b0);
  endtask

  // watchdog
  initial begin
    #(N_OPS * 80 * 20);
    fail_and_stop("Timeout: result never arrived");
  end

  // ==============================
  // main sequence
  // ==============================
  initial begin
    void'($urandom(58221));
    clk            = 1'b0;
    rst_n          = 1'b1; // reset is active high
    div_valid_i    = 1'b0;
    div_op_i       = `DIV_OP_DIV;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);
    check_flag("div_ready_o", div_ready_o, 1'b1);
    check_flag("result_valid_o", result_valid_o, 1'b0);

    for (int i = 0; i < N_64; i++) begin
      run_op(OPS_64[$urandom_range(3)],
             ($urandom_range(7) == 0) ? xlen_t'($urandom_range(100)) : rand_word(),
             mixed_value(), 1'b0);
    end

    // garbage in the upper half of both operands
    for (int i = 0; i < N_W; i++) begin
      xlen_t b;
      b        = mixed_value();
      b[63:32] = $urandom;
      run_op(OPS_W[$urandom_range(3)], rand_word(), b, 1'b0);
    end

    for (int i = 0; i < 4; i++) begin
      run_op(OPS_64[i], rand_word(), '0, 1'b0);
      run_op(OPS_W[i], rand_word(), {$urandom, 32'h0}, 1'b0);
    end
    run_op(`DIV_OP_DIV, MIN_X, '1, 1'b0);
    run_op(`DIV_OP_REM, MIN_X, '1, 1'b0);
    run_op(`DIV_OP_DIVW, {$urandom, MIN_W}, {$urandom, 32'hffff_ffff}, 1'b0);
    run_op(`DIV_OP_REMW, {$urandom, MIN_W}, {$urandom, 32'hffff_ffff}, 1'b0);

    for (int i = 0; i < N_BP; i++) begin
      run_op(($urandom_range(1) == 1) ? OPS_64[$urandom_range(3)] : OPS_W[$urandom_range(3)],
             rand_word(), mixed_value(), 1'b1);
    end

    @(negedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+verilog
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/div_iter_core.sv
verilog/div_result_sel.sv
verilog/div_unit.sv
bench/div_unit_tb.sv

// File: Makefile
# Verilator build and run of the divide unit testbench

SIM  := obj_dir/div_unit_tb
SRCS := $(filter-out +%,$(shell cat files.f)) verilog/div_cfg.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): files.f $(SRCS)
	verilator --binary --top-module div_unit_tb -f files.f --Mdir obj_dir -o div_unit_tb

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
